// File: hdl/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // fetch side widths
    ////////////////////////////////////////////////////////////

    typedef logic [27:0]  fip_t;   // line address, byte address bits 31:4
    typedef logic [19:0]  vpn_t;   // fip bits 27:8
    typedef logic [19:0]  pfn_t;   // physical frame from the itlb
    typedef logic [127:0] line_t;  // one 16-byte fetch line

    // control flow sources, highest code wins in fetch_top
    typedef enum logic [1:0] {
        CF_NONE,
        CF_BP,
        CF_WB,
        CF_INIT
    } cf_sel_e;

    // even and odd pointers interleave, so each one skips a line
    localparam fip_t FETCH_STRIDE = 28'd2;

endpackage

// File: hdl/mem_pkg.sv
package mem_pkg;

    typedef logic [10:0] pline_t;  // {pfn[2:0], fip[7:0]}
    typedef logic [14:0] paddr_t;  // {pline, 4'b0} plus beat offset
    typedef logic [31:0] word_t;   // apb data

    typedef enum logic [1:0] {
        R_IDLE,
        R_SETUP,
        R_ACCESS,
        R_DONE
    } refill_state_e;

endpackage

// File: hdl/fetch_ptr_select.sv
`timescale 1ns/1ps

module fetch_ptr_select #(
    parameter fetch_pkg::fip_t RESET_FIP = '0
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  fetch_pkg::cf_sel_e cf_sel_i,
    input  fetch_pkg::fip_t    init_fip_i,
    input  fetch_pkg::fip_t    wb_fip_i,
    input  fetch_pkg::fip_t    bp_fip_i,
    input  logic               advance_i,
    output fetch_pkg::fip_t    fip_o
);
    import fetch_pkg::*;

    fip_t fip_q;
    fip_t fip_d;

    // control flow beats the sequential advance
    always_comb begin
        case (cf_sel_i)
            CF_INIT: fip_d = init_fip_i;
            CF_WB:   fip_d = wb_fip_i;
            CF_BP:   fip_d = bp_fip_i;
            default: fip_d = advance_i ? fip_q + FETCH_STRIDE : fip_q;  // hold on stall
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fip_q <= RESET_FIP;
        end else begin
            fip_q <= fip_d;
        end
    end

    assign fip_o = fip_q;

    // a plain advance never moves the pointer into the other bank
    a_parity_kept: assert property (@(posedge clk) disable iff (!rst_n_i)
        (advance_i && cf_sel_i == CF_NONE)
        |=> fip_o[0] == RESET_FIP[0])
        else $error("fetch pointer left its bank after advance");

endmodule

// File: hdl/itlb.sv
`timescale 1ns/1ps

module itlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  fetch_pkg::vpn_t                                  vpn_i,
    input  logic [TLB_ENTRIES*$bits(fetch_pkg::vpn_t)-1:0]   vp_i,
    input  logic [TLB_ENTRIES*$bits(fetch_pkg::pfn_t)-1:0]   pf_i,
    input  logic [TLB_ENTRIES-1:0]                           entry_v_i,
    input  logic [TLB_ENTRIES-1:0]                           entry_p_i,
    input  logic [TLB_ENTRIES-1:0]                           entry_pcd_i,
    output fetch_pkg::pfn_t                                  pfn_o,
    output logic                                             tlb_miss_o,
    output logic                                             prot_fault_o
);
    import fetch_pkg::*;

    localparam int VPN_W = $bits(vpn_t);
    localparam int PFN_W = $bits(pfn_t);

    logic [TLB_ENTRIES-1:0] hit_vec;
    pfn_t                   pfn_sel;

    // tag compare on every entry in parallel
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_cmp
        assign hit_vec[i] = entry_v_i[i] & entry_p_i[i]
                          & (vp_i[i*VPN_W +: VPN_W] == vpn_i);
    end

    // or-mux of the frame, only one entry may hit
    always_comb begin
        pfn_sel = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                pfn_sel = pfn_sel | pf_i[i*PFN_W +: PFN_W];
            end
        end
    end

    assign pfn_o        = pfn_sel;
    assign tlb_miss_o   = ~|hit_vec;
    assign prot_fault_o = |(hit_vec & entry_pcd_i);  // fetch from mmio page

    // duplicate mappings in the loaded table would corrupt the or-mux
    always_comb begin
        a_one_hit: assert final ($isunknown(hit_vec) || $onehot0(hit_vec))
            else $error("itlb: more than one entry matches vpn %h", vpn_i);
    end

endmodule

// File: hdl/icache_bank.sv
`timescale 1ns/1ps

module icache_bank #(
    parameter int CACHE_SETS = 16
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  fetch_pkg::fip_t   fip_i,
    input  fetch_pkg::pfn_t   pfn_i,
    input  logic              tlb_miss_i,
    input  logic              prot_fault_i,
    output fetch_pkg::line_t  line_o,
    output logic              line_valid_o,
    output logic              refill_req_o,
    output mem_pkg::pline_t   refill_pline_o,
    input  logic              refill_done_i,
    input  fetch_pkg::line_t  refill_line_i
);
    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int IDX_W = $clog2(CACHE_SETS);
    localparam int PL_W  = $bits(pline_t);
    localparam int TAG_W = PL_W - IDX_W - 1;  // bit 0 is the bank select

    typedef enum logic {
        B_IDLE,
        B_WAIT
    } bank_state_e;

    bank_state_e      state_q;
    pline_t           pline;
    pline_t           pline_q;    // address of the pending refill
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] idx_q;
    logic [TAG_W-1:0] tag;
    logic [TAG_W-1:0] tag_q;
    line_t            data_mem [CACHE_SETS];
    logic [TAG_W-1:0] tag_mem [CACHE_SETS];
    logic [CACHE_SETS-1:0] valid_q;
    logic             hit;
    logic             fault;

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign pline = {pfn_i[2:0], fip_i[7:0]};
    assign idx   = pline[IDX_W:1];
    assign tag   = pline[PL_W-1:IDX_W+1];
    assign idx_q = pline_q[IDX_W:1];
    assign tag_q = pline_q[PL_W-1:IDX_W+1];

    assign fault        = tlb_miss_i | prot_fault_i;
    assign hit          = valid_q[idx] && (tag_mem[idx] == tag);
    assign line_o       = data_mem[idx];
    assign line_valid_o = hit & ~fault;  // also advances the pointer

    ////////////////////////////////////////////////////////////
    // miss handling
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= B_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                B_IDLE: begin
                    if (!hit && !fault) begin
                        state_q <= B_WAIT;
                    end
                end
                B_WAIT: begin
                    if (refill_done_i) begin  // fill lands, hit next cycle
                        valid_q[idx_q] <= 1'b1;
                        state_q        <= B_IDLE;
                    end
                end
                default: state_q <= B_IDLE;
            endcase
        end
    end

    // line and tag storage, written only by a refill
    always_ff @(posedge clk) begin
        if (state_q == B_IDLE) begin
            pline_q <= pline;  // frozen while the request is out
        end
        if (state_q == B_WAIT && refill_done_i) begin
            data_mem[idx_q] <= refill_line_i;
            tag_mem[idx_q]  <= tag_q;
        end
    end

    assign refill_req_o   = (state_q == B_WAIT);
    assign refill_pline_o = pline_q;

    // the refill unit may sample the address on any cycle of the request
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (refill_req_o && !refill_done_i) |=> (refill_req_o && $stable(refill_pline_o)))
        else $error("refill request dropped or changed before done");

endmodule

// File: hdl/refill_apb_master.sv
`timescale 1ns/1ps

module refill_apb_master (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_even_i,
    input  mem_pkg::pline_t   pline_even_i,
    output logic              done_even_o,
    input  logic              req_odd_i,
    input  mem_pkg::pline_t   pline_odd_i,
    output logic              done_odd_o,
    output fetch_pkg::line_t  line_o,
    output logic              psel_o,
    output logic              penable_o,
    output mem_pkg::paddr_t   paddr_o,
    input  mem_pkg::word_t    prdata_i,
    input  logic              pready_i
);
    import fetch_pkg::*;
    import mem_pkg::*;

    refill_state_e state_q;
    logic          prio_odd_q;  // round robin, even goes first after reset
    logic          gnt_odd_q;   // bank being served
    logic          pick_odd;
    logic [1:0]    beat_q;
    pline_t        pline_q;
    line_t         line_q;

    // odd wins only when even is idle or it is odd's turn
    assign pick_odd = req_odd_i & (~req_even_i | prio_odd_q);

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= R_IDLE;
            prio_odd_q <= 1'b0;
            gnt_odd_q  <= 1'b0;
            beat_q     <= '0;
        end else begin
            case (state_q)
                R_IDLE: begin
                    if (req_even_i || req_odd_i) begin
                        gnt_odd_q <= pick_odd;
                        beat_q    <= '0;
                        state_q   <= R_SETUP;
                    end
                end
                R_SETUP: state_q <= R_ACCESS;
                R_ACCESS: begin
                    if (pready_i) begin
                        beat_q  <= beat_q + 2'd1;
                        state_q <= (beat_q == 2'd3) ? R_DONE : R_SETUP;
                    end
                end
                R_DONE: begin
                    prio_odd_q <= ~gnt_odd_q;  // hand the turn over
                    state_q    <= R_IDLE;
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

    // address and data path
    always_ff @(posedge clk) begin
        if (state_q == R_IDLE) begin
            pline_q <= pick_odd ? pline_odd_i : pline_even_i;
        end
        if (state_q == R_ACCESS && pready_i) begin
            line_q <= {prdata_i, line_q[127:32]};  // word k ends at bits 32k+31:32k
        end
    end

    assign psel_o      = (state_q == R_SETUP) || (state_q == R_ACCESS);
    assign penable_o   = (state_q == R_ACCESS);
    assign paddr_o     = {pline_q, beat_q, 2'b00};
    assign done_even_o = (state_q == R_DONE) & ~gnt_odd_q;
    assign done_odd_o  = (state_q == R_DONE) & gnt_odd_q;
    assign line_o      = line_q;

    a_en_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        penable_o |-> psel_o)
        else $error("apb penable without psel");

    // address held from setup through the last wait state
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (psel_o && (!penable_o || !pready_i)) |=> (penable_o && $stable(paddr_o)))
        else $error("apb address moved during transfer");

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int TLB_ENTRIES = 8,
    parameter int CACHE_SETS  = 16
) (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  logic                                            init_i,
    input  logic [31:0]                                     init_addr_i,
    input  logic                                            resteer_i,
    input  fetch_pkg::fip_t                                 wb_fip_even_i,
    input  fetch_pkg::fip_t                                 wb_fip_odd_i,
    input  logic                                            bp_taken_i,
    input  fetch_pkg::fip_t                                 bp_fip_even_i,
    input  fetch_pkg::fip_t                                 bp_fip_odd_i,
    input  logic [TLB_ENTRIES*$bits(fetch_pkg::vpn_t)-1:0]  vp_i,
    input  logic [TLB_ENTRIES*$bits(fetch_pkg::pfn_t)-1:0]  pf_i,
    input  logic [TLB_ENTRIES-1:0]                          entry_v_i,
    input  logic [TLB_ENTRIES-1:0]                          entry_p_i,
    input  logic [TLB_ENTRIES-1:0]                          entry_pcd_i,
    output fetch_pkg::fip_t                                 fip_even_o,
    output fetch_pkg::fip_t                                 fip_odd_o,
    output fetch_pkg::line_t                                line_even_o,
    output fetch_pkg::line_t                                line_odd_o,
    output logic                                            line_valid_even_o,
    output logic                                            line_valid_odd_o,
    output logic                                            tlb_miss_even_o,
    output logic                                            tlb_miss_odd_o,
    output logic                                            prot_fault_even_o,
    output logic                                            prot_fault_odd_o,
    output logic                                            psel_o,
    output logic                                            penable_o,
    output mem_pkg::paddr_t                                 paddr_o,
    input  mem_pkg::word_t                                  prdata_i,
    input  logic                                            pready_i
);
    import fetch_pkg::*;
    import mem_pkg::*;

    cf_sel_e cf_sel;
    fip_t    init_line;
    fip_t    init_line_p1;
    fip_t    init_fip_even;
    fip_t    init_fip_odd;
    pfn_t    pfn_even;
    pfn_t    pfn_odd;
    pline_t  pline_even;
    pline_t  pline_odd;
    logic    req_even;
    logic    req_odd;
    logic    done_even;
    logic    done_odd;
    line_t   refill_line;

    ////////////////////////////////////////////////////////////
    // control flow priority and init split
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (init_i)          cf_sel = CF_INIT;
        else if (resteer_i)  cf_sel = CF_WB;
        else if (bp_taken_i) cf_sel = CF_BP;
        else                 cf_sel = CF_NONE;
    end

    assign init_line     = init_addr_i[31:4];
    assign init_line_p1  = init_line + 28'd1;
    assign init_fip_even = init_line[0] ? init_line_p1 : init_line;  // even gets the even one
    assign init_fip_odd  = init_line[0] ? init_line : init_line_p1;

    ////////////////////////////////////////////////////////////
    // even slice
    ////////////////////////////////////////////////////////////

    fetch_ptr_select #(.RESET_FIP(28'd0)) u_ptr_even (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cf_sel_i   (cf_sel),
        .init_fip_i (init_fip_even),
        .wb_fip_i   (wb_fip_even_i),
        .bp_fip_i   (bp_fip_even_i),
        .advance_i  (line_valid_even_o),
        .fip_o      (fip_even_o)
    );

    itlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_itlb_even (
        .vpn_i        (fip_even_o[27:8]),
        .vp_i         (vp_i),
        .pf_i         (pf_i),
        .entry_v_i    (entry_v_i),
        .entry_p_i    (entry_p_i),
        .entry_pcd_i  (entry_pcd_i),
        .pfn_o        (pfn_even),
        .tlb_miss_o   (tlb_miss_even_o),
        .prot_fault_o (prot_fault_even_o)
    );

    icache_bank #(.CACHE_SETS(CACHE_SETS)) u_bank_even (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fip_i          (fip_even_o),
        .pfn_i          (pfn_even),
        .tlb_miss_i     (tlb_miss_even_o),
        .prot_fault_i   (prot_fault_even_o),
        .line_o         (line_even_o),
        .line_valid_o   (line_valid_even_o),
        .refill_req_o   (req_even),
        .refill_pline_o (pline_even),
        .refill_done_i  (done_even),
        .refill_line_i  (refill_line)
    );

    ////////////////////////////////////////////////////////////
    // odd slice
    ////////////////////////////////////////////////////////////

    fetch_ptr_select #(.RESET_FIP(28'd1)) u_ptr_odd (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cf_sel_i   (cf_sel),
        .init_fip_i (init_fip_odd),
        .wb_fip_i   (wb_fip_odd_i),
        .bp_fip_i   (bp_fip_odd_i),
        .advance_i  (line_valid_odd_o),
        .fip_o      (fip_odd_o)
    );

    itlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_itlb_odd (
        .vpn_i        (fip_odd_o[27:8]),
        .vp_i         (vp_i),
        .pf_i         (pf_i),
        .entry_v_i    (entry_v_i),
        .entry_p_i    (entry_p_i),
        .entry_pcd_i  (entry_pcd_i),
        .pfn_o        (pfn_odd),
        .tlb_miss_o   (tlb_miss_odd_o),
        .prot_fault_o (prot_fault_odd_o)
    );

    icache_bank #(.CACHE_SETS(CACHE_SETS)) u_bank_odd (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fip_i          (fip_odd_o),
        .pfn_i          (pfn_odd),
        .tlb_miss_i     (tlb_miss_odd_o),
        .prot_fault_i   (prot_fault_odd_o),
        .line_o         (line_odd_o),
        .line_valid_o   (line_valid_odd_o),
        .refill_req_o   (req_odd),
        .refill_pline_o (pline_odd),
        .refill_done_i  (done_odd),
        .refill_line_i  (refill_line)
    );

    // one shared refill path, line bus fans out to both banks
    refill_apb_master u_refill (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_even_i   (req_even),
        .pline_even_i (pline_even),
        .done_even_o  (done_even),
        .req_odd_i    (req_odd),
        .pline_odd_i  (pline_odd),
        .done_odd_o   (done_odd),
        .line_o       (refill_line),
        .psel_o       (psel_o),
        .penable_o    (penable_o),
        .paddr_o      (paddr_o),
        .prdata_i     (prdata_i),
        .pready_i     (pready_i)
    );

endmodule

// File: testbench/apb_mem_model.sv
`timescale 1ns/1ps

module apb_mem_model (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic [14:0] paddr_i,
    input  logic [1:0]  wait_cycles_i,  // wait states for the next transfer
    output logic [31:0] prdata_o,
    output logic        pready_o
);

    logic [1:0] wait_q;
    logic [1:0] cnt_q;

    // wait count is latched in the setup phase and counted in the access phase
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wait_q <= '0;
            cnt_q  <= '0;
        end else if (psel_i && !penable_i) begin
            wait_q <= wait_cycles_i;
            cnt_q  <= '0;
        end else if (psel_i && penable_i && !pready_o) begin
            cnt_q <= cnt_q + 2'd1;
        end
    end

    assign pready_o = psel_i && penable_i && (cnt_q == wait_q);

    // every word is a hash of its own byte address
    assign prdata_o = {17'd0, paddr_i} * 32'h9e3779b1;

endmodule

// File: testbench/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;
    import mem_pkg::*;

    // about 1000 cycles of stimulus, with room for slow refills
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int PRIO_ROUNDS    = 40;
    localparam fip_t HOME_EVEN    = 28'h540;
    localparam fip_t HOME_ODD     = 28'h541;

    logic        clk;
    logic        rst_n;
    logic        init;
    logic [31:0] init_addr;
    logic        resteer;
    logic        bp;
    fip_t        wb_e, wb_o, bp_e, bp_o;
    fip_t        exp_init_e, exp_init_o;
    logic [159:0] vp, pf;
    logic [7:0]  ent_v, ent_p, ent_pcd;
    fip_t        fip_even_o, fip_odd_o;
    line_t       line_even_o, line_odd_o;
    logic        line_valid_even_o, line_valid_odd_o;
    logic        tlb_miss_even_o, tlb_miss_odd_o;
    logic        prot_fault_even_o, prot_fault_odd_o;
    logic        psel_o, penable_o, pready;
    paddr_t      paddr_o;
    word_t       prdata;
    logic [1:0]  wait_cycles;
    logic [31:0] rng_state;
    logic        revisit;
    logic [3:0]  quiet_cnt;
    logic [1:0]  beat_cnt;
    pline_t      beat_base;
    int          cycle_cnt;
    logic        cf_idle;
    logic        fault_e, fault_o;

    assign cf_idle = !init && !resteer && !bp;
    assign fault_e = tlb_miss_even_o | prot_fault_even_o;
    assign fault_o = tlb_miss_odd_o | prot_fault_odd_o;

    always #10 clk = ~clk;

    fetch_top #(.TLB_ENTRIES(8), .CACHE_SETS(16)) u_dut (
        .clk (clk), .rst_n_i (rst_n),
        .init_i (init), .init_addr_i (init_addr), .resteer_i (resteer),
        .wb_fip_even_i (wb_e), .wb_fip_odd_i (wb_o),
        .bp_taken_i (bp), .bp_fip_even_i (bp_e), .bp_fip_odd_i (bp_o),
        .vp_i (vp), .pf_i (pf), .entry_v_i (ent_v), .entry_p_i (ent_p),
        .entry_pcd_i (ent_pcd),
        .fip_even_o (fip_even_o), .fip_odd_o (fip_odd_o),
        .line_even_o (line_even_o), .line_odd_o (line_odd_o),
        .line_valid_even_o (line_valid_even_o), .line_valid_odd_o (line_valid_odd_o),
        .tlb_miss_even_o (tlb_miss_even_o), .tlb_miss_odd_o (tlb_miss_odd_o),
        .prot_fault_even_o (prot_fault_even_o), .prot_fault_odd_o (prot_fault_odd_o),
        .psel_o (psel_o), .penable_o (penable_o), .paddr_o (paddr_o),
        .prdata_i (prdata), .pready_i (pready)
    );

    apb_mem_model u_mem (
        .clk (clk), .rst_n_i (rst_n), .psel_i (psel_o), .penable_i (penable_o),
        .paddr_i (paddr_o), .wait_cycles_i (wait_cycles),
        .prdata_o (prdata), .pready_o (pready)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // pages 0..5 map to frame vpn+3, page 6 is mmio, page 7 and up unmapped
    function automatic line_t exp_line(input fip_t f);
        logic [2:0] pfn_lo;
        paddr_t     base;
        line_t      l;
        pfn_lo = f[10:8] + 3'd3;
        base   = {pfn_lo, f[7:0], 4'b0000};
        for (int k = 0; k < 4; k++) begin
            l[32*k +: 32] = {17'd0, base + paddr_t'(4 * k)} * 32'h9e3779b1;
        end
        return l;
    endfunction

    function automatic logic exp_miss(input fip_t f);
        return f[27:8] > 20'd6;
    endfunction

    function automatic logic exp_pcd(input fip_t f);
        return f[27:8] == 20'd6;
    endfunction

    // random line on a normal page, parity forced to the bank
    function automatic fip_t rand_fip(input logic [31:0] r, input logic odd);
        return {17'd0, 3'(r % 32'd6), r[7:1], odd};
    endfunction

    function automatic logic [31:0] draw_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = draw_random();
        wait_cycles = r[1:0];
    endtask

    task automatic load_init(input logic [31:0] addr);
        fip_t l;
        l = addr[31:4];
        init_addr  = addr;
        exp_init_e = l[0] ? l + 28'd1 : l;
        exp_init_o = l[0] ? l : l + 28'd1;
    endtask

    task automatic stop_failed();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        stop_failed();
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_line_even: assert property (@(posedge clk) disable iff (!rst_n)
        line_valid_even_o |-> line_even_o == exp_line(fip_even_o))
        else report_error($sformatf("even line wrong at fip %h", fip_even_o));
    a_line_odd: assert property (@(posedge clk) disable iff (!rst_n)
        line_valid_odd_o |-> line_odd_o == exp_line(fip_odd_o))
        else report_error($sformatf("odd line wrong at fip %h", fip_odd_o));

    a_adv_even: assert property (@(posedge clk) disable iff (!rst_n)
        (cf_idle && line_valid_even_o) |=> fip_even_o == $past(fip_even_o) + FETCH_STRIDE)
        else report_error("even pointer did not advance");
    a_hold_even: assert property (@(posedge clk) disable iff (!rst_n)
        (cf_idle && !line_valid_even_o) |=> $stable(fip_even_o))
        else report_error("even pointer moved while stalled");
    a_adv_odd: assert property (@(posedge clk) disable iff (!rst_n)
        (cf_idle && line_valid_odd_o) |=> fip_odd_o == $past(fip_odd_o) + FETCH_STRIDE)
        else report_error("odd pointer did not advance");
    a_hold_odd: assert property (@(posedge clk) disable iff (!rst_n)
        (cf_idle && !line_valid_odd_o) |=> $stable(fip_odd_o))
        else report_error("odd pointer moved while stalled");

    // init > resteer > branch prediction
    a_prio_init: assert property (@(posedge clk) disable iff (!rst_n)
        init |=> fip_even_o == $past(exp_init_e) && fip_odd_o == $past(exp_init_o))
        else report_error("init target not loaded");
    a_prio_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (!init && resteer) |=> fip_even_o == $past(wb_e) && fip_odd_o == $past(wb_o))
        else report_error("resteer target not loaded");
    a_prio_bp: assert property (@(posedge clk) disable iff (!rst_n)
        (!init && !resteer && bp) |=> fip_even_o == $past(bp_e) && fip_odd_o == $past(bp_o))
        else report_error("branch target not loaded");

    a_fault_flags: assert property (@(posedge clk) disable iff (!rst_n)
        tlb_miss_even_o == exp_miss(fip_even_o) && tlb_miss_odd_o == exp_miss(fip_odd_o)
        && prot_fault_even_o == exp_pcd(fip_even_o) && prot_fault_odd_o == exp_pcd(fip_odd_o))
        else report_error("tlb miss or protection fault flag wrong");
    a_fault_no_line: assert property (@(posedge clk) disable iff (!rst_n)
        !(fault_e && line_valid_even_o) && !(fault_o && line_valid_odd_o))
        else report_error("line valid on a faulting fetch");
    a_fault_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (quiet_cnt >= 4'd3 && fault_e && fault_o) |-> !psel_o)
        else report_error("apb transfer started with both pointers faulted");

    a_apb_setup: assert property (@(posedge clk) disable iff (!rst_n)
        (psel_o && !penable_o) |=> (psel_o && penable_o && $stable(paddr_o)))
        else report_error("apb setup not followed by access");
    a_apb_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable_o) |-> $past(psel_o && !penable_o))
        else report_error("apb access without setup");
    a_apb_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (penable_o && !pready) |=> (penable_o && $stable(paddr_o)))
        else report_error("apb address moved before pready");
    a_revisit: assert property (@(posedge clk) disable iff (!rst_n)
        revisit |-> (line_valid_even_o && line_valid_odd_o && !psel_o))
        else report_error("refilled line missed on re-fetch");

    // beats of one refill go to base +0, +4, +8, +12
    always @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (psel_o && penable_o && pready) begin
            beat_cnt  <= beat_cnt + 2'd1;
            beat_base <= paddr_o[14:4];
            a_beat_order: assert (paddr_o[3:0] == {beat_cnt, 2'b00}
                                  && (beat_cnt == 2'd0 || paddr_o[14:4] == beat_base))
                else report_error($sformatf("apb beat %0d at address %h", beat_cnt, paddr_o));
        end
    end

    always @(posedge clk) begin
        if (!rst_n || !(fault_e && fault_o && !psel_o)) begin
            quiet_cnt <= '0;
        end else if (quiet_cnt != 4'hf) begin
            quiet_cnt <= quiet_cnt + 4'd1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: test sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
            stop_failed();
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic        seen_e;
        logic        seen_o;
        clk = 1'b0;
        rst_n = 1'b0;
        rng_state = 32'hde6fd4d1;
        cycle_cnt = 0;
        {init, resteer, bp, revisit} = '0;
        init_addr = '0;
        {wb_e, wb_o, bp_e, bp_o} = '0;
        {exp_init_e, exp_init_o} = '0;
        wait_cycles = '0;
        for (int i = 0; i < 8; i++) begin
            vp[i*20 +: 20] = 20'(i);
            pf[i*20 +: 20] = 20'((i + 3) % 8);
        end
        ent_v   = 8'hff;
        ent_p   = 8'h7f;  // page 7 not present
        ent_pcd = 8'h40;  // page 6 is mmio
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (300) next_cycle();  // sequential fetch from page 0

        for (int i = 0; i < PRIO_ROUNDS; i++) begin
            r = draw_random();
            {bp, resteer, init} = r[2:0];
            r = draw_random();
            wb_e = rand_fip(r, 1'b0);
            r = draw_random();
            wb_o = rand_fip(r, 1'b1);
            r = draw_random();
            bp_e = rand_fip(r, 1'b0);
            r = draw_random();
            bp_o = rand_fip(r, 1'b1);
            r = draw_random();
            load_init({rand_fip(r, r[20]), r[15:12]});
            next_cycle();
            {init, resteer, bp} = '0;
            r = draw_random();
            repeat (r[2:0]) next_cycle();
        end

        // fetch a home pair, park both pointers on faulting pages, come back
        load_init({HOME_EVEN, 4'h0});
        init = 1'b1;
        next_cycle();
        init = 1'b0;
        seen_e = 1'b0;
        seen_o = 1'b0;
        while (!(seen_e && seen_o)) begin
            seen_e = seen_e | (line_valid_even_o && fip_even_o == HOME_EVEN);
            seen_o = seen_o | (line_valid_odd_o && fip_odd_o == HOME_ODD);
            next_cycle();
        end
        wb_e = 28'h740;  // unmapped page, frame 0 aliases the cached home line
        wb_o = 28'h621;  // mmio page
        resteer = 1'b1;
        next_cycle();
        resteer = 1'b0;
        while (quiet_cnt < 4'd6) next_cycle();
        repeat (10) next_cycle();
        load_init({HOME_EVEN, 4'h0});
        init = 1'b1;
        next_cycle();
        init = 1'b0;
        revisit = 1'b1;
        next_cycle();
        revisit = 1'b0;

        repeat (100) next_cycle();
        $display("No errors");
        $finish;
    end

endmodule

// File: fetch_top.f
hdl/fetch_pkg.sv
hdl/mem_pkg.sv
hdl/fetch_ptr_select.sv
hdl/itlb.sv
hdl/icache_bank.sv
hdl/refill_apb_master.sv
hdl/fetch_top.sv
testbench/apb_mem_model.sv
testbench/tb_fetch_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch_top testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_top.f --top-module tb_fetch_top -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
